//--- rtl/main_bus_macros.svh
`ifndef MAIN_BUS_MACROS_SVH
`define MAIN_BUS_MACROS_SVH

// CPU bus widths, address counted in words from A1
`define MB_AW 23
`define MB_DW 16

// Programmable mapper
`define MB_REGIONS 8
`define MB_MAP_WIN 8'hFF

// I/O sub-windows, taken from A11..A8
`define MB_SUB_CAB 4'd0
`define MB_SUB_VID 4'd1
`define MB_SUB_MUL 4'd2
`define MB_SUB_CMP 4'd3

// Chip select to DTACKn for internal regions
`define MB_DTACK_DLY 2

// Region 0 after reset covers the program ROM pages
`define MB_RST_BASE0 8'h00
`define MB_RST_MASK0 8'h0F

`endif

//--- rtl/main_bus_pkg.sv
`include "main_bus_macros.svh"

package main_bus_pkg;

    typedef enum logic [2:0] {
        REG_ROM  = 3'd0,
        REG_RAM  = 3'd1,
        REG_VRAM = 3'd2,    // char RAM when A16 is set
        REG_PAL  = 3'd3,
        REG_OBJ  = 3'd4,
        REG_IO   = 3'd5
    } region_e;

    typedef struct packed {
        logic [`MB_AW:1]   addr;
        logic [`MB_DW-1:0] dout;
        logic              rnw;
        logic              asn;
        logic              udsn;
        logic              ldsn;
    } cpu_bus_t;

    // Even mapper registers
    typedef struct packed {
        logic [7:0] base;
        logic [7:0] mask;
    } map_base_t;

    // Odd mapper registers
    typedef struct packed {
        logic [11:0] rsvd;
        logic        en;
        region_e     kind;
    } map_ctrl_t;

    typedef union packed {
        map_base_t as_base;
        map_ctrl_t as_ctrl;
    } map_word_u;

    typedef struct packed {
        logic              wr;
        logic              sel;
        logic [3:0]        addr;    // A4..A1, peripherals use the low two bits
        logic [`MB_DW-1:0] din;
        logic [1:0]        be;
    } periph_req_t;

    typedef struct packed {
        logic [`MB_REGIONS-1:0] hits;
        region_e                kind;
    } region_hit_t;

    // Byte-lane write into a 16-bit register
    function automatic logic [15:0] merge_word(input logic [15:0] old, input periph_req_t req);
        return {req.be[1] ? req.din[15:8] : old[15:8], req.be[0] ? req.din[7:0] : old[7:0]};
    endfunction

endpackage

//--- rtl/region_mapper.sv
`timescale 1ns/1ns
`include "main_bus_macros.svh"

module region_mapper import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  periph_req_t req,
    input  logic [7:0]  page,
    output region_hit_t hit,
    output logic [15:0] rd_data
);

    logic [7:0]             base [`MB_REGIONS];
    logic [7:0]             mask [`MB_REGIONS];
    region_e                kind [`MB_REGIONS];
    logic [`MB_REGIONS-1:0] en;
    logic [`MB_REGIONS-1:0] match;
    map_word_u              wr_word;
    map_word_u              rd_word;
    logic [2:0]             idx;

    assign wr_word = req.din;
    // Two registers per entry
    assign idx     = req.addr[3:1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MB_REGIONS; i++) begin
                base[i] <= (i == 0) ? `MB_RST_BASE0 : 8'h00;
                mask[i] <= (i == 0) ? `MB_RST_MASK0 : 8'h00;
                kind[i] <= REG_ROM;
            end
            en <= `MB_REGIONS'(1);
        end else if (req.wr) begin
            if (!req.addr[0]) begin
                if (req.be[1]) base[idx] <= wr_word.as_base.base;
                if (req.be[0]) mask[idx] <= wr_word.as_base.mask;
            end else if (req.be[0]) begin
                en[idx]   <= wr_word.as_ctrl.en;
                kind[idx] <= wr_word.as_ctrl.kind;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (req.addr[0]) begin
            rd_word.as_ctrl.en   = en[idx];
            rd_word.as_ctrl.kind = kind[idx];
        end else begin
            rd_word.as_base.base = base[idx];
            rd_word.as_base.mask = mask[idx];
        end
    end

    assign rd_data = req.sel ? rd_word : 16'h0000;

    // Mask bits set to one are don't-care
    always_comb begin
        hit.kind = REG_ROM;
        for (int i = `MB_REGIONS - 1; i >= 0; i--) begin
            match[i] = en[i] && ((page ^ base[i]) & ~mask[i]) == 8'h00;
            if (match[i]) hit.kind = kind[i];
        end
        // Keep only the lowest matching entry
        hit.hits = match & (~match + 1'b1);
    end

    // Reported kind must come from the one winning entry
    a_single_winner: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hit.hits) &&
        (hit.hits == '0 || hit.kind == kind[$countones(hit.hits - 1'b1)]))
        else $error("region_mapper: winner not unique or kind from another entry");

endmodule

//--- rtl/bus_ctrl.sv
`timescale 1ns/1ns
`include "main_bus_macros.svh"

module bus_ctrl import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    bus,
    input  region_hit_t hit,
    input  logic        rom_ok,
    input  logic        ram_ok,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [15:0] map_data,
    input  logic [15:0] mul_data,
    input  logic [15:0] cmp_data,
    input  logic [15:0] cab_data,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic        char_cs,
    output logic        pal_cs,
    output logic        objram_cs,
    output periph_req_t map_req,
    output periph_req_t mul_req,
    output periph_req_t cmp_req,
    output periph_req_t cab_req,
    output periph_req_t vid_req,
    output logic [15:0] cpu_din,
    output logic        dtackn
);

    logic        ds_act;
    logic        acc_on;
    logic        map_win;
    logic        hit_any;
    logic        io_cs;
    logic        map_cs;
    logic        none_cs;
    logic        int_cs;
    logic        ext_ok;
    logic        ack_now;
    logic        dtack_q;
    logic        wr_first;
    logic [1:0]  dly_cnt;
    logic [3:0]  io_sub;
    logic [15:0] rd_mux;

    assign ds_act  = !bus.udsn || !bus.ldsn;
    // A data strobe, or the read phase of a read-modify-write
    assign acc_on  = !bus.asn && (ds_act || bus.rnw);
    assign map_win = bus.addr[23:16] == `MB_MAP_WIN;
    assign hit_any = |hit.hits && !map_win;
    assign io_sub  = bus.addr[11:8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs} <= '0;
            {io_cs, map_cs, none_cs} <= '0;
        end else if (acc_on) begin
            rom_cs    <= hit_any && hit.kind == REG_ROM && bus.rnw;
            ram_cs    <= hit_any && hit.kind == REG_RAM && ds_act;
            vram_cs   <= hit_any && hit.kind == REG_VRAM && !bus.addr[16] && ds_act;
            char_cs   <= hit_any && hit.kind == REG_VRAM && bus.addr[16];
            pal_cs    <= hit_any && hit.kind == REG_PAL;
            objram_cs <= hit_any && hit.kind == REG_OBJ;
            io_cs     <= hit_any && hit.kind == REG_IO;
            map_cs    <= map_win;
            // Unmapped pages and writes to ROM still get a DTACK
            none_cs   <= !map_win && (!(|hit.hits) || (hit.kind == REG_ROM && !bus.rnw));
        end else begin
            {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs} <= '0;
            {io_cs, map_cs, none_cs} <= '0;
        end
    end

    assign int_cs = char_cs | pal_cs | objram_cs | io_cs | map_cs | none_cs;
    assign ext_ok = (rom_cs && rom_ok) || ((ram_cs || vram_cs) && ram_ok);
    assign ack_now = (int_cs && dly_cnt == 2'(`MB_DTACK_DLY)) || ext_ok;

    // Fixed wait for internal regions
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dly_cnt <= 2'd0;
        end else if (!int_cs) begin
            dly_cnt <= 2'd0;
        end else if (dly_cnt != 2'(`MB_DTACK_DLY)) begin
            dly_cnt <= dly_cnt + 2'd1;
        end
    end

    // Acknowledge latch, holds until AS goes away
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtack_q <= 1'b0;
            cpu_din <= 16'h0000;
        end else if (bus.asn) begin
            dtack_q <= 1'b0;
        end else if (ack_now && !dtack_q) begin
            dtack_q <= 1'b1;
            cpu_din <= rd_mux;
        end
    end

    assign dtackn = bus.asn || !dtack_q;

    always_comb begin
        if (rom_cs) begin
            rd_mux = rom_data;
        end else if (ram_cs || vram_cs) begin
            rd_mux = ram_data;
        end else if (char_cs) begin
            rd_mux = char_dout;
        end else if (pal_cs) begin
            rd_mux = pal_dout;
        end else if (objram_cs) begin
            rd_mux = obj_dout;
        end else if (map_cs) begin
            rd_mux = map_data;
        end else if (io_cs) begin
            case (io_sub)
                `MB_SUB_CAB: rd_mux = cab_data;
                `MB_SUB_MUL: rd_mux = mul_data;
                `MB_SUB_CMP: rd_mux = cmp_data;
                default:     rd_mux = 16'hFFFF;
            endcase
        end else begin
            rd_mux = 16'hFFFF;
        end
    end

    // Write strobe only on the first select cycle
    assign wr_first = !bus.rnw && dly_cnt == 2'd0;

    function automatic periph_req_t make_req(input logic sel);
        periph_req_t r;
        r.wr   = sel && wr_first;
        r.sel  = sel;
        r.addr = bus.addr[4:1];
        r.din  = bus.dout;
        r.be   = ~{bus.udsn, bus.ldsn};
        return r;
    endfunction

    always_comb begin
        map_req = make_req(map_cs);
        mul_req = make_req(io_cs && io_sub == `MB_SUB_MUL);
        cmp_req = make_req(io_cs && io_sub == `MB_SUB_CMP);
        cab_req = make_req(io_cs && io_sub == `MB_SUB_CAB);
        vid_req = make_req(io_cs && io_sub == `MB_SUB_VID);
    end

    a_cs_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs, map_cs, none_cs}))
        else $error("bus_ctrl: several chip selects active");

    a_dtack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        !dtackn |-> !bus.asn && (int_cs || rom_cs || ram_cs || vram_cs))
        else $error("bus_ctrl: DTACKn low outside a selected access");

endmodule

//--- rtl/mul_unit.sv
`timescale 1ns/1ns

module mul_unit import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  periph_req_t req,
    output logic [15:0] rd_data
);

    logic signed [15:0] op_a;
    logic signed [15:0] op_b;
    logic signed [31:0] prod;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_a <= 16'sd0;
            op_b <= 16'sd0;
            prod <= 32'sd0;
        end else begin
            // Product follows the operands one cycle later
            prod <= op_a * op_b;
            if (req.wr && req.addr[1:0] == 2'd0) op_a <= merge_word(op_a, req);
            if (req.wr && req.addr[1:0] == 2'd1) op_b <= merge_word(op_b, req);
        end
    end

    always_comb begin
        case (req.addr[1:0])
            2'd0:    rd_data = op_a;
            2'd1:    rd_data = op_b;
            2'd2:    rd_data = prod[15:0];
            default: rd_data = prod[31:16];
        endcase
    end

endmodule

//--- rtl/cmp_unit.sv
`timescale 1ns/1ns

module cmp_unit import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  periph_req_t req,
    output logic [15:0] rd_data
);

    logic signed [15:0] bound0;
    logic signed [15:0] bound1;
    logic signed [15:0] value;
    logic signed [15:0] lo;
    logic signed [15:0] hi;
    logic signed [15:0] clamped;
    logic               below;
    logic               above;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bound0 <= 16'sd0;
            bound1 <= 16'sd0;
            value  <= 16'sd0;
        end else if (req.wr) begin
            case (req.addr[1:0])
                2'd0:    bound0 <= merge_word(bound0, req);
                2'd1:    bound1 <= merge_word(bound1, req);
                2'd2:    value  <= merge_word(value, req);
                default: ;
            endcase
        end
    end

    // Bounds may be written in either order
    assign lo = (bound0 < bound1) ? bound0 : bound1;
    assign hi = (bound0 < bound1) ? bound1 : bound0;

    assign below   = value < lo;
    assign above   = value > hi;
    assign clamped = below ? lo : (above ? hi : value);

    always_comb begin
        case (req.addr[1:0])
            2'd0:    rd_data = bound0;
            2'd1:    rd_data = bound1;
            2'd2:    rd_data = {13'd0, !below && !above, above, below};
            default: rd_data = clamped;
        endcase
    end

endmodule

//--- rtl/cab_io.sv
`timescale 1ns/1ns

module cab_io import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  periph_req_t cab_req,
    input  periph_req_t vid_req,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    output logic [15:0] rd_data,
    output logic        flip,
    output logic        video_en,
    output logic [5:0]  tile_bank
);

    // Video control only listens to the low byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip      <= 1'b0;
            video_en  <= 1'b0;
            tile_bank <= 6'd0;
        end else if (vid_req.wr && vid_req.be[0]) begin
            case (vid_req.addr[1:0])
                2'd0: begin
                    video_en <= vid_req.din[0];
                    flip     <= vid_req.din[1];
                end
                2'd2:    tile_bank[2:0] <= vid_req.din[2:0];
                2'd3:    tile_bank[5:3] <= vid_req.din[2:0];
                default: ;
            endcase
        end
    end

    // Upper byte floats high except on the DIP switch word
    always_comb begin
        case (cab_req.addr[1:0])
            2'd0:    rd_data = {8'hFF, 2'b11, start_button, 1'b1, service, coin_input};
            2'd1:    rd_data = {8'hFF, joystick1};
            2'd2:    rd_data = {8'hFF, joystick2};
            default: rd_data = {dipsw_b, dipsw_a};
        endcase
    end

endmodule

//--- rtl/main_bus_top.sv
`timescale 1ns/1ns

module main_bus_top import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    bus,

    // ROM and RAM
    output logic        rom_cs,
    output logic [18:1] rom_addr,
    input  logic [15:0] rom_data,
    input  logic        rom_ok,
    output logic        ram_cs,
    output logic        vram_cs,
    input  logic [15:0] ram_data,
    input  logic        ram_ok,

    // Video memories
    output logic        char_cs,
    output logic        pal_cs,
    output logic        objram_cs,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,

    output logic [15:0] cpu_din,
    output logic        dtackn,

    // Cabinet
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    output logic        flip,
    output logic        video_en,
    output logic [5:0]  tile_bank
);

    region_hit_t hit;
    periph_req_t map_req;
    periph_req_t mul_req;
    periph_req_t cmp_req;
    periph_req_t cab_req;
    periph_req_t vid_req;
    logic [15:0] map_data;
    logic [15:0] mul_data;
    logic [15:0] cmp_data;
    logic [15:0] cab_data;

    assign rom_addr = bus.addr[18:1];

    region_mapper u_mapper (
        .clk     (clk),
        .rst     (rst),
        .req     (map_req),
        .page    (bus.addr[23:16]),
        .hit     (hit),
        .rd_data (map_data)
    );

    bus_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .hit       (hit),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .map_data  (map_data),
        .mul_data  (mul_data),
        .cmp_data  (cmp_data),
        .cab_data  (cab_data),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .map_req   (map_req),
        .mul_req   (mul_req),
        .cmp_req   (cmp_req),
        .cab_req   (cab_req),
        .vid_req   (vid_req),
        .cpu_din   (cpu_din),
        .dtackn    (dtackn)
    );

    mul_unit u_mul (
        .clk     (clk),
        .rst     (rst),
        .req     (mul_req),
        .rd_data (mul_data)
    );

    cmp_unit u_cmp (
        .clk     (clk),
        .rst     (rst),
        .req     (cmp_req),
        .rd_data (cmp_data)
    );

    cab_io u_cab (
        .clk          (clk),
        .rst          (rst),
        .cab_req      (cab_req),
        .vid_req      (vid_req),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .rd_data      (cab_data),
        .flip         (flip),
        .video_en     (video_en),
        .tile_bank    (tile_bank)
    );

endmodule

//--- bench/main_bus_checker.sv
`timescale 1ns/1ns
`include "main_bus_macros.svh"

module main_bus_checker import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    bus,
    input  logic [5:0]  exp_cs,
    input  logic [15:0] exp_data,
    input  logic [7:0]  exp_vid,
    input  logic        rom_cs,
    input  logic        ram_cs,
    input  logic        vram_cs,
    input  logic        char_cs,
    input  logic        pal_cs,
    input  logic        objram_cs,
    input  logic        rom_ok,
    input  logic        ram_ok,
    input  logic [15:0] cpu_din,
    input  logic        dtackn,
    input  logic        flip,
    input  logic        video_en,
    input  logic [5:0]  tile_bank,
    output int          checks,
    output int          errors
);

    // Sampled one edge after DTACKn falls, which is three cycles after the first AS edge
    localparam int int_ack_edge = `MB_DTACK_DLY + 2;

    logic [5:0]  cs_now;
    logic [15:0] vid_now;
    logic        ext_ok;
    logic        asn_q;
    logic        acked;
    logic        armed;
    logic [15:0] held_din;
    int          edges;
    int          ok_edges;

    assign cs_now  = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs};
    assign vid_now = {8'h00, video_en, flip, tile_bank};
    assign ext_ok  = (rom_cs && rom_ok) || ((ram_cs || vram_cs) && ram_ok);

    initial begin
        checks = 0;
        errors = 0;
    end

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic note_fault(input string msg);
        errors++;
        $display("%s at %0t ns", msg, $time);
    endtask

    // Inputs move on the falling edge, so the rising edge sees them settled
    always @(posedge clk) begin
        if (rst) begin
            armed    <= 1'b1;
            asn_q    <= 1'b1;
            acked    <= 1'b0;
            edges    <= 0;
            ok_edges <= 0;
            held_din <= 16'h0000;
        end else begin
            asn_q <= bus.asn;
            if (armed) begin
                armed <= 1'b0;
                check_value("chip selects after reset", {10'd0, cs_now}, 16'h0000);
                check_value("cpu_din after reset", cpu_din, 16'h0000);
                check_value("video state after reset", vid_now, 16'h0000);
                if (!dtackn)
                    note_fault("DTACKn is low right after reset");
            end
            if (bus.asn) begin
                edges    <= 0;
                ok_edges <= 0;
                acked    <= 1'b0;
                if (!dtackn)
                    note_fault("DTACKn is low while AS is high");
                if (asn_q && cs_now != 6'd0)
                    note_fault("A chip select is still active a cycle after AS rose");
                if (asn_q && !armed) begin
                    check_value("cpu_din between accesses", cpu_din, held_din);
                    check_value("video state", vid_now, {8'h00, exp_vid});
                end
            end else begin
                edges <= edges + 1;
                if (ext_ok)
                    ok_edges <= ok_edges + 1;
                if (!dtackn && !acked) begin
                    acked    <= 1'b1;
                    held_din <= cpu_din;
                    check_value("chip selects", {10'd0, cs_now}, {10'd0, exp_cs});
                    if (bus.rnw)
                        check_value("read data", cpu_din, exp_data);
                    // ROM, RAM and VRAM wait on their ok level
                    if (|exp_cs[5:3]) begin
                        if (ok_edges != 1)
                            note_fault("DTACKn did not fall one cycle after the memory ok");
                    end else if (edges != int_ack_edge) begin
                        note_fault($sformatf("Internal DTACKn seen at access edge %0d, not %0d",
                                             edges, int_ack_edge));
                    end
                end
            end
        end
    end

endmodule

//--- bench/main_bus_tb.sv
`timescale 1ns/1ns

module main_bus_tb import main_bus_pkg::*; ();

    // One-hot select patterns, {rom, ram, vram, char, pal, obj}
    localparam logic [5:0] cs_none = 6'b000000;
    localparam logic [5:0] cs_rom  = 6'b100000;
    localparam logic [5:0] cs_ram  = 6'b010000;
    localparam logic [5:0] cs_vram = 6'b001000;
    localparam logic [5:0] cs_char = 6'b000100;
    localparam logic [5:0] cs_pal  = 6'b000010;
    localparam logic [5:0] cs_obj  = 6'b000001;

    // Cabinet pins, steady for the whole run
    localparam logic [7:0] joy1  = 8'h5C;
    localparam logic [7:0] joy2  = 8'hA3;
    localparam logic [1:0] start = 2'b10;
    localparam logic [1:0] coin  = 2'b01;
    localparam logic       svc   = 1'b0;
    localparam logic [7:0] dip_a = 8'h3C;
    localparam logic [7:0] dip_b = 8'hC5;

    typedef struct packed {
        logic [23:0] addr;
        logic [15:0] wdata;
        logic        rnw;
        logic [1:0]  be;
        logic [2:0]  dly;
        logic [15:0] exp;
        logic [5:0]  cs;
        logic [7:0]  vid;
    } step_t;

    logic        clk;
    logic        rst;
    cpu_bus_t    bus;
    logic        rom_cs;
    logic        ram_cs;
    logic        vram_cs;
    logic        char_cs;
    logic        pal_cs;
    logic        objram_cs;
    logic [18:1] rom_addr;
    logic [15:0] rom_data;
    logic [15:0] ram_data;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic        rom_ok;
    logic        ram_ok;
    logic [15:0] cpu_din;
    logic        dtackn;
    logic        flip;
    logic        video_en;
    logic [5:0]  tile_bank;
    logic [5:0]  exp_cs;
    logic [15:0] exp_data;
    logic [7:0]  exp_vid;
    // Video state after each step, {video_en, flip, tile_bank}
    logic [7:0]  vid_now;
    logic [2:0]  ok_dly;
    int          ok_wait;
    int          cycles;
    int          cycle_limit;
    int          checks;
    int          errors;
    step_t       steps [$];

    main_bus_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus),
        .rom_cs       (rom_cs),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .ram_cs       (ram_cs),
        .vram_cs      (vram_cs),
        .ram_data     (ram_data),
        .ram_ok       (ram_ok),
        .char_cs      (char_cs),
        .pal_cs       (pal_cs),
        .objram_cs    (objram_cs),
        .char_dout    (char_dout),
        .pal_dout     (pal_dout),
        .obj_dout     (obj_dout),
        .cpu_din      (cpu_din),
        .dtackn       (dtackn),
        .joystick1    (joy1),
        .joystick2    (joy2),
        .start_button (start),
        .coin_input   (coin),
        .service      (svc),
        .dipsw_a      (dip_a),
        .dipsw_b      (dip_b),
        .flip         (flip),
        .video_en     (video_en),
        .tile_bank    (tile_bank)
    );

    main_bus_checker chk0 (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .exp_cs    (exp_cs),
        .exp_data  (exp_data),
        .exp_vid   (exp_vid),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .cpu_din   (cpu_din),
        .dtackn    (dtackn),
        .flip      (flip),
        .video_en  (video_en),
        .tile_bank (tile_bank),
        .checks    (checks),
        .errors    (errors)
    );

    // Memory models, data follows the word address
    assign rom_data  = rom_addr[16:1] ^ 16'hA5A5;
    assign ram_data  = bus.addr[16:1];
    assign char_dout = bus.addr[16:1] ^ 16'hC3C3;
    assign pal_dout  = bus.addr[16:1] ^ 16'h5A5A;
    assign obj_dout  = bus.addr[16:1] ^ 16'h0F0F;

    // ROM and RAM answer ok_dly cycles after their select
    always @(negedge clk) begin
        if (rom_cs || ram_cs || vram_cs) begin
            rom_ok  <= rom_cs && ok_wait >= ok_dly;
            ram_ok  <= (ram_cs || vram_cs) && ok_wait >= ok_dly;
            ok_wait <= ok_wait + 1;
        end else begin
            rom_ok  <= 1'b0;
            ram_ok  <= 1'b0;
            ok_wait <= 0;
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles, the stimulus table did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] mem_word(input logic [23:0] a);
        return a[16:1];
    endfunction

    task automatic add_step(input logic [23:0] a, input logic [15:0] d, input logic rnw,
                            input logic [1:0] be, input logic [15:0] exp, input logic [5:0] cs);
        step_t s;
        s.addr  = a;
        s.wdata = d;
        s.rnw   = rnw;
        s.be    = be;
        s.dly   = 3'($urandom % 8);
        s.exp   = exp;
        s.cs    = cs;
        s.vid   = vid_now;
        steps.push_back(s);
    endtask

    task automatic add_read(input logic [23:0] a, input logic [15:0] exp, input logic [5:0] cs);
        add_step(a, 16'h0000, 1'b1, 2'b11, exp, cs);
    endtask

    task automatic add_write(input logic [23:0] a, input logic [15:0] d, input logic [1:0] be,
                             input logic [5:0] cs);
        add_step(a, d, 1'b0, be, 16'h0000, cs);
    endtask

    task automatic build_steps();
        logic [7:0]         map_base [6] = '{8'h40, 8'h42, 8'h50, 8'h60, 8'h70, 8'h40};
        logic [7:0]         map_mask [6] = '{8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'h03};
        region_e            map_kind [6] = '{REG_RAM, REG_VRAM, REG_PAL, REG_OBJ, REG_IO, REG_PAL};
        logic signed [15:0] ma;
        logic signed [15:0] mb;
        logic signed [31:0] mp;
        int                 lo;
        int                 hi;
        int                 val [3];
        logic [23:0]        a;

        // ROM pages 00..0F right after reset
        a = 24'h001234;
        add_read(a, mem_word(a) ^ 16'hA5A5, cs_rom);
        a = 24'h0ABCDE;
        add_read(a, mem_word(a) ^ 16'hA5A5, cs_rom);
        a = 24'h0F0002;
        add_read(a, mem_word(a) ^ 16'hA5A5, cs_rom);

        // Entries 1..6, entry 6 overlaps pages 40..43 at lower priority
        for (int e = 1; e <= 6; e++) begin
            add_write(24'hFF0000 + 24'(4 * e), {map_base[e-1], map_mask[e-1]}, 2'b11, cs_none);
            add_write(24'hFF0002 + 24'(4 * e), {12'h000, 1'b1, map_kind[e-1]}, 2'b11, cs_none);
        end
        add_read(24'hFF0000, 16'h000F, cs_none);
        add_read(24'hFF0004, 16'h4000, cs_none);
        add_read(24'hFF0016, 16'h000D, cs_none);
        add_read(24'hFF001E, 16'h0000, cs_none);

        a = 24'h400010;
        add_read(a, mem_word(a), cs_ram);
        a = 24'h420020;
        add_read(a, mem_word(a), cs_vram);
        a = 24'h430040;
        add_read(a, mem_word(a) ^ 16'hC3C3, cs_char);
        a = 24'h500100;
        add_read(a, mem_word(a) ^ 16'h5A5A, cs_pal);
        a = 24'h600200;
        add_read(a, mem_word(a) ^ 16'h0F0F, cs_obj);
        // Only entry 6 covers page 41
        a = 24'h410008;
        add_read(a, mem_word(a) ^ 16'h5A5A, cs_pal);
        add_write(24'h400012, 16'h1234, 2'b01, cs_ram);
        add_read(24'h800000, 16'hFFFF, cs_none);

        // Multiplier in I/O sub-window 2
        for (int r = 0; r < 2; r++) begin
            ma = 16'($urandom);
            mb = 16'($urandom);
            mp = ma * mb;
            add_write(24'h700200, ma, 2'b11, cs_none);
            add_write(24'h700202, mb, 2'b11, cs_none);
            add_read(24'h700204, mp[15:0], cs_none);
            add_read(24'h700206, mp[31:16], cs_none);
            add_read(24'h700200, ma, cs_none);
        end

        // Compare unit, values below, above and inside the bounds
        lo = int'($urandom % 2000) - 1000;
        hi = lo + 1 + int'($urandom % 1000);
        val[0] = lo - 1 - int'($urandom % 100);
        val[1] = hi + 1 + int'($urandom % 100);
        val[2] = lo + (hi - lo) / 2;
        add_write(24'h700300, 16'(lo), 2'b11, cs_none);
        add_write(24'h700302, 16'(hi), 2'b11, cs_none);
        for (int k = 0; k < 3; k++) begin
            add_write(24'h700304, 16'(val[k]), 2'b11, cs_none);
            add_read(24'h700304, 16'(1 << k), cs_none);
            add_read(24'h700306, 16'((k == 0) ? lo : (k == 1) ? hi : val[k]), cs_none);
        end
        add_write(24'h700300, 16'(hi), 2'b11, cs_none);
        add_write(24'h700302, 16'(lo), 2'b11, cs_none);
        add_write(24'h700304, 16'(val[0]), 2'b11, cs_none);
        add_read(24'h700304, 16'h0001, cs_none);
        add_read(24'h700306, 16'(lo), cs_none);

        // Cabinet inputs
        add_read(24'h700000, {8'hFF, 2'b11, start, 1'b1, svc, coin}, cs_none);
        add_read(24'h700002, {8'hFF, joy1}, cs_none);
        add_read(24'h700004, {8'hFF, joy2}, cs_none);
        add_read(24'h700006, {dip_b, dip_a}, cs_none);

        // Video control
        vid_now[7:6] = 2'b11;
        add_write(24'h700100, 16'h0003, 2'b11, cs_none);
        vid_now[2:0] = 3'd5;
        add_write(24'h700104, 16'h0005, 2'b11, cs_none);
        vid_now[5:3] = 3'd6;
        add_write(24'h700106, 16'h0006, 2'b11, cs_none);
        add_write(24'h700100, 16'hFC00, 2'b10, cs_none);
        add_write(24'h700104, 16'h0201, 2'b10, cs_none);
        add_write(24'h700106, 16'h0701, 2'b10, cs_none);
        vid_now[7:6] = 2'b10;
        add_write(24'h700100, 16'h0001, 2'b01, cs_none);
    endtask

    task automatic run_step(input step_t s);
        @(negedge clk);
        exp_cs   = s.cs;
        exp_data = s.exp;
        exp_vid  = s.vid;
        ok_dly   = s.dly;
        bus.addr = s.addr[23:1];
        bus.dout = s.wdata;
        bus.rnw  = s.rnw;
        bus.udsn = !s.be[1];
        bus.ldsn = !s.be[0];
        bus.asn  = 1'b0;
        do
            @(negedge clk);
        while (dtackn);
        // AS stays low through the edge that latches DTACKn
        @(negedge clk);
        bus.asn  = 1'b1;
        bus.udsn = 1'b1;
        bus.ldsn = 1'b1;
        bus.rnw  = 1'b1;
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(62533));
        rst      = 1'b1;
        bus      = '0;
        bus.rnw  = 1'b1;
        bus.asn  = 1'b1;
        bus.udsn = 1'b1;
        bus.ldsn = 1'b1;
        rom_ok   = 1'b0;
        ram_ok   = 1'b0;
        ok_dly   = 3'd0;
        ok_wait  = 0;
        cycles   = 0;
        exp_cs   = cs_none;
        exp_data = 16'h0000;
        exp_vid  = 8'h00;
        vid_now  = 8'h00;
        build_steps();
        cycle_limit = steps.size() * 20 + 100;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        foreach (steps[i])
            run_step(steps[i]);
        repeat (2) @(negedge clk);
        $display("steps %0d, checks %0d, errors %0d", steps.size(), checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/main_bus_pkg.sv
rtl/region_mapper.sv
rtl/bus_ctrl.sv
rtl/mul_unit.sv
rtl/cmp_unit.sv
rtl/cab_io.sv
rtl/main_bus_top.sv
bench/main_bus_checker.sv
bench/main_bus_tb.sv

//--- Bender.yml
package:
  name: main_bus

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/main_bus_pkg.sv
      - rtl/region_mapper.sv
      - rtl/bus_ctrl.sv
      - rtl/mul_unit.sv
      - rtl/cmp_unit.sv
      - rtl/cab_io.sv
      - rtl/main_bus_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/main_bus_checker.sv
      - bench/main_bus_tb.sv
